// ==== hdl/cart_pkg.sv ====
/*
 * Shared widths, constants and the enable sequencer state type for the
 * cartridge loader. Modules name these types by scope in their port lists
 * and import the package inside the body where they need more of it.
 */
package cart_pkg;

	// ====================
	// Data widths
	// ====================
	typedef logic [7:0]   byte_t;         // Download, ROM store and cheat byte
	typedef logic [24:0]  ioctl_addr_t;   // Host download offset
	typedef logic [7:0]   ioctl_index_t;  // Host file type
	typedef logic [21:0]  rom_addr_t;     // 4 MiB cartridge space
	typedef logic [127:0] cheat_code_t;   // Flags, address, compare, replace

	// ====================
	// Enable sequencer
	// ====================
	localparam int CE_PERIOD = 30;  // System clocks per enable cycle

	typedef enum logic [4:0] {
		PH_0,  PH_1,  PH_2,  PH_3,  PH_4,
		PH_5,  PH_6,  PH_7,  PH_8,  PH_9,
		PH_10, PH_11, PH_12, PH_13, PH_14,
		PH_15, PH_16, PH_17, PH_18, PH_19,
		PH_20, PH_21, PH_22, PH_23, PH_24,
		PH_25, PH_26, PH_27, PH_28, PH_29
	} ce_phase_t;

	// ====================
	// Download decoding
	// ====================
	localparam int HEADER_BYTES = 512;  // Copier header in front of some dumps

	// All ones index carries a cheat record, not a cart
	localparam ioctl_index_t CHEAT_INDEX = 8'hFF;

	// Low index bits of a Game Gear image
	localparam logic [4:0] GG_INDEX = 5'd2;

endpackage

// ==== hdl/ce_sequencer.sv ====
/*
 * Clock enable generator for the console core. A phase counter runs
 * through one 30 clock cycle and fixed phases are decoded into
 * registered CPU, VDP, pixel and sprite enables.
 */
module ce_sequencer (
	input  logic clk_sys,
	input  logic rst,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);
	import cart_pkg::*;

	ce_phase_t phase;

	// Phase counter, wraps after CE_PERIOD states
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase <= PH_0;
		end else if (phase == ce_phase_t'(CE_PERIOD - 1)) begin
			phase <= PH_0;
		end else begin
			phase <= ce_phase_t'(phase + 5'd1);
		end
	end

	// ====================
	// Enable decode
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ce_sp  <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
		end else begin
			ce_sp  <= phase[0];  // Even period keeps it toggling
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
			case (phase)
				PH_4, PH_9, PH_14, PH_19, PH_24, PH_29: ce_vdp <= 1'b1;
				default: ;
			endcase
			case (phase)
				PH_9, PH_19, PH_29: ce_pix <= 1'b1;
				default: ;
			endcase
			case (phase)
				PH_9, PH_24: ce_cpu <= 1'b1;  // Late CPU phase keeps the HCounter timing
				default: ;
			endcase
		end
	end

	// CPU must always step together with the VDP
	a_cpu_with_vdp: assert property (@(posedge clk_sys) disable iff (rst)
		ce_cpu |-> ce_vdp);

endmodule

// ==== hdl/rom_download.sv ====
/*
 * Front stage of the loader. Splits the host download into cart and
 * cheat traffic, holds the host with ioctl_wait while the ROM store
 * finishes each write, and hands registered byte strobes to the
 * geometry and cheat stages.
 */
module rom_download (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 ioctl_download,
	input  cart_pkg::ioctl_index_t ioctl_index,
	input  logic                 ioctl_wr,
	input  cart_pkg::ioctl_addr_t  ioctl_addr,
	input  cart_pkg::byte_t        ioctl_dout,
	input  logic                 rom_wr_ack,
	output logic                 ioctl_wait,
	output logic                 rom_wr,
	output cart_pkg::rom_addr_t    rom_waddr,
	output cart_pkg::byte_t        rom_wdata,
	output logic                 cart_active,
	output logic                 cart_wr,
	output cart_pkg::rom_addr_t    cart_waddr,
	output logic                 code_wr,
	output logic [3:0]           code_slot,
	output cart_pkg::byte_t        code_byte,
	output logic                 game_gear
);
	import cart_pkg::*;

	logic code_index;
	logic cart_dl;
	logic code_dl;
	logic cart_byte;
	logic wr_done;

	assign code_index = (ioctl_index == CHEAT_INDEX);
	assign cart_dl    = ioctl_download & ~code_index;
	assign code_dl    = ioctl_download & code_index;
	assign cart_byte  = ioctl_wr & cart_dl;
	assign wr_done    = ioctl_wait & (rom_wr == rom_wr_ack);  // Store caught up

	// ====================
	// Write handshake
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_active <= 1'b0;
			ioctl_wait  <= 1'b0;
			rom_wr      <= 1'b0;
			rom_waddr   <= '0;
			game_gear   <= 1'b0;
		end else begin
			cart_active <= cart_dl;
			if (cart_byte) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;  // Toggle starts one store write
				game_gear  <= (ioctl_index[4:0] == GG_INDEX);
			end else if (wr_done) begin
				ioctl_wait <= 1'b0;
			end
			// New cart restarts the write counter
			if (cart_dl && !cart_active) begin
				rom_waddr <= '0;
			end else if (wr_done) begin
				rom_waddr <= rom_waddr + 1'b1;
			end
		end
	end

	// Byte for the store, held through the handshake
	always_ff @(posedge clk_sys) begin
		if (cart_byte) begin
			rom_wdata  <= ioctl_dout;
			cart_waddr <= ioctl_addr[$bits(rom_addr_t)-1:0];  // Keeps the last offset
		end
	end

	// ====================
	// Strobes to later stages
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_wr <= 1'b0;
			code_wr <= 1'b0;
		end else begin
			cart_wr <= cart_byte;
			code_wr <= ioctl_wr & code_dl;
		end
	end

	always_ff @(posedge clk_sys) begin
		code_slot <= ioctl_addr[3:0];
		code_byte <= ioctl_dout;
	end

	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wait |-> !ioctl_wr);

	// Only one store write in flight
	a_rom_wr_steady: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wait |=> $stable(rom_wr));

endmodule

// ==== hdl/cart_geometry.sv ====
/*
 * Tracks the shape of the loaded cartridge. Address masks are built
 * from the offsets seen during the download, a copier header is
 * detected from the loaded size, and CPU ROM reads are mapped into
 * the stored image without the header.
 */
module cart_geometry #(
	parameter int HEADER_BYTES = cart_pkg::HEADER_BYTES
) (
	input  logic              clk_sys,
	input  logic              rst,
	input  logic              cart_active,
	input  logic              cart_wr,
	input  cart_pkg::rom_addr_t cart_waddr,
	input  cart_pkg::rom_addr_t cpu_rom_addr,
	output cart_pkg::rom_addr_t rom_raddr
);
	import cart_pkg::*;

	localparam int HDR_BIT = $clog2(HEADER_BYTES);
	localparam rom_addr_t HDR_OFS = rom_addr_t'(HEADER_BYTES);

	rom_addr_t plain_mask;
	rom_addr_t hdr_mask;
	rom_addr_t end_size;
	logic      active_d;
	logic      has_header;

	assign end_size = cart_waddr + 1'b1;  // One past the last offset

	// ====================
	// Mask accumulation
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			plain_mask <= '0;
			hdr_mask   <= '0;
		end else if (cart_wr) begin
			plain_mask <= plain_mask | cart_waddr;
			hdr_mask   <= hdr_mask | (cart_waddr - HDR_OFS);
			// First byte of each view starts a fresh mask
			if (cart_waddr == '0) begin
				plain_mask <= '0;
			end
			if (cart_waddr == HDR_OFS) begin
				hdr_mask <= '0;
			end
		end
	end

	// Header flag at the end of the download
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			active_d   <= 1'b0;
			has_header <= 1'b0;
		end else begin
			active_d <= cart_active;
			if (active_d && !cart_active) begin
				has_header <= end_size[HDR_BIT];  // Odd number of header blocks
			end
		end
	end

	// ====================
	// Read mapping
	// ====================
	always_comb begin
		if (has_header) begin
			rom_raddr = (cpu_rom_addr + HDR_OFS) & hdr_mask;
		end else begin
			rom_raddr = cpu_rom_addr & plain_mask;
		end
	end

	// Offsets only arrive during a cart download
	a_wr_in_cart: assert property (@(posedge clk_sys) disable iff (rst)
		cart_wr |-> cart_active);

endmodule

// ==== hdl/cheat_assembler.sv ====
/*
 * Collects one 16 byte cheat record into a 128 bit code. Each group of
 * four slots fills one 32 bit field, least significant byte first,
 * and the last slot pulses cheat_valid for one cycle.
 */
module cheat_assembler (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                code_wr,
	input  logic [3:0]          code_slot,
	input  cart_pkg::byte_t       code_byte,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                cheat_valid
);

	logic [6:0] bit_pos;
	logic       last_slot;

	// Field 0 (flags) sits at the top, so the field number is inverted
	assign bit_pos   = {~code_slot[3:2], code_slot[1:0], 3'b000};
	assign last_slot = (code_slot == 4'hF);

	// ====================
	// Byte placement
	// ====================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat_code[bit_pos +: 8] <= code_byte;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr & last_slot;  // Code complete
		end
	end

	// Valid never lasts more than a cycle
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (rst)
		cheat_valid |=> !cheat_valid);

endmodule

// ==== hdl/cart_loader_top.sv ====
/*
 * Cartridge loading glue for a Master System / Game Gear core. The
 * download front end feeds the geometry and cheat stages, and the
 * enable sequencer runs beside them. The ROM store sits outside and
 * answers each toggled write on rom_wr_ack.
 */
module cart_loader_top #(
	parameter int HEADER_BYTES = cart_pkg::HEADER_BYTES
) (
	input  logic                  clk_sys,
	input  logic                  rst,

	// Host download
	input  logic                  ioctl_download,
	input  cart_pkg::ioctl_index_t  ioctl_index,
	input  logic                  ioctl_wr,
	input  cart_pkg::ioctl_addr_t   ioctl_addr,
	input  cart_pkg::byte_t         ioctl_dout,
	output logic                  ioctl_wait,

	// ROM store write side
	output logic                  rom_wr,
	output cart_pkg::rom_addr_t     rom_waddr,
	output cart_pkg::byte_t         rom_wdata,
	input  logic                  rom_wr_ack,

	// CPU read mapping
	input  cart_pkg::rom_addr_t     cpu_rom_addr,
	output cart_pkg::rom_addr_t     rom_raddr,

	output logic                  game_gear,
	output cart_pkg::cheat_code_t   cheat_code,
	output logic                  cheat_valid,

	// Clock enables
	output logic                  ce_cpu,
	output logic                  ce_vdp,
	output logic                  ce_pix,
	output logic                  ce_sp
);
	import cart_pkg::*;

	logic       cart_active;
	logic       cart_wr;
	rom_addr_t  cart_waddr;
	logic       code_wr;
	logic [3:0] code_slot;
	byte_t      code_byte;

	// ====================
	// Enables
	// ====================
	ce_sequencer ce_sequencer_i (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	// ====================
	// Download pipeline
	// ====================
	rom_download rom_download_i (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_wr_ack     (rom_wr_ack),
		.ioctl_wait     (ioctl_wait),
		.rom_wr         (rom_wr),
		.rom_waddr      (rom_waddr),
		.rom_wdata      (rom_wdata),
		.cart_active    (cart_active),
		.cart_wr        (cart_wr),
		.cart_waddr     (cart_waddr),
		.code_wr        (code_wr),
		.code_slot      (code_slot),
		.code_byte      (code_byte),
		.game_gear      (game_gear)
	);

	cart_geometry #(
		.HEADER_BYTES (HEADER_BYTES)
	) cart_geometry_i (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.cart_active  (cart_active),
		.cart_wr      (cart_wr),
		.cart_waddr   (cart_waddr),
		.cpu_rom_addr (cpu_rom_addr),
		.rom_raddr    (rom_raddr)
	);

	cheat_assembler cheat_assembler_i (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.code_wr     (code_wr),
		.code_slot   (code_slot),
		.code_byte   (code_byte),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

endmodule

// ==== verif/tb_checks.sv ====
/*
 * Concurrent checks on the loader's top level ports, clocked by the
 * DUT clock. Covers enable spacing, the download handshake, reset
 * values and the cheat valid timing. A failing property raises
 * violation for the testbench top.
 */
module tb_checks (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   ioctl_download,
	input  cart_pkg::ioctl_index_t ioctl_index,
	input  logic                   ioctl_wr,
	input  logic [3:0]             ioctl_slot,
	input  cart_pkg::byte_t        ioctl_dout,
	input  logic                   ioctl_wait,
	input  logic                   rom_wr,
	input  cart_pkg::rom_addr_t    rom_waddr,
	input  cart_pkg::byte_t        rom_wdata,
	input  logic                   rom_wr_ack,
	input  logic                   cheat_valid,
	input  logic                   ce_cpu,
	input  logic                   ce_vdp,
	input  logic                   ce_pix,
	input  logic                   ce_sp,
	output logic                   violation
);
	import cart_pkg::*;

	logic       cheat_dl;
	logic       cart_write;
	logic       last_slot_write;
	logic       flagged = 1'b0;
	logic [2:0] pulse;
	logic [2:0] seen;   // A first pulse has gone by
	int         gap [3];

	assign cheat_dl        = ioctl_download & (ioctl_index == CHEAT_INDEX);
	assign cart_write      = ioctl_wr & ioctl_download & (ioctl_index != CHEAT_INDEX);
	assign last_slot_write = ioctl_wr & cheat_dl & (ioctl_slot == 4'hF);
	assign pulse           = {ce_cpu, ce_pix, ce_vdp};
	assign violation       = flagged;

	task automatic flag_violation(input string what);
		$display("Check failed at %0t: %s", $time, what);
		flagged = 1'b1;
	endtask

	// Cycles since the last pulse of each enable
	always @(posedge clk_sys) begin
		for (int e = 0; e < 3; e++) begin
			gap[e]  <= (rst || pulse[e]) ? 1 : gap[e] + 1;
			seen[e] <= !rst && (seen[e] || pulse[e]);
		end
	end

	// ====================
	// Clock enables
	// ====================
	a_reset_quiet: assert property (@(posedge clk_sys) rst |=>
		!(ce_cpu || ce_vdp || ce_pix || ce_sp) && !ioctl_wait && !rom_wr && !cheat_valid)
		else flag_violation("an output is high while reset is applied");
	a_sp_toggle: assert property (@(posedge clk_sys) disable iff (rst)
		(!$past(rst) && !$past(rst, 2)) |-> ce_sp != $past(ce_sp))
		else flag_violation("ce_sp did not alternate");
	a_vdp_gap: assert property (@(posedge clk_sys) disable iff (rst)
		(ce_vdp && seen[0]) |-> gap[0] == 5) else flag_violation("ce_vdp spacing is not 5");
	a_pix_gap: assert property (@(posedge clk_sys) disable iff (rst)
		(ce_pix && seen[1]) |-> gap[1] == 10) else flag_violation("ce_pix spacing is not 10");
	a_cpu_gap: assert property (@(posedge clk_sys) disable iff (rst)
		(ce_cpu && seen[2]) |-> gap[2] == 15) else flag_violation("ce_cpu spacing is not 15");
	a_pix_vdp: assert property (@(posedge clk_sys) ce_pix |-> ce_vdp)
		else flag_violation("ce_pix came without ce_vdp");
	a_cpu_vdp: assert property (@(posedge clk_sys) ce_cpu |-> ce_vdp)
		else flag_violation("ce_cpu came without ce_vdp");

	// ====================
	// Download handshake
	// ====================
	a_wr_starts: assert property (@(posedge clk_sys) disable iff (rst)
		cart_write |=> ioctl_wait && (rom_wr != $past(rom_wr)) && rom_wdata == $past(ioctl_dout))
		else flag_violation("a cart byte did not start a ROM write with its data");
	a_wait_holds: assert property (@(posedge clk_sys) disable iff (rst)
		(ioctl_wait && rom_wr != rom_wr_ack) |=> ioctl_wait)
		else flag_violation("ioctl_wait fell while the acknowledge lagged");
	a_wait_release: assert property (@(posedge clk_sys) disable iff (rst)
		$fell(ioctl_wait) |-> $past(rom_wr == rom_wr_ack))
		else flag_violation("ioctl_wait fell before the acknowledge");
	a_addr_step: assert property (@(posedge clk_sys) disable iff (rst)
		$fell(ioctl_wait) |-> rom_waddr == $past(rom_waddr) + rom_addr_t'(1))
		else flag_violation("rom_waddr did not step by one after a write");
	a_cheat_no_store: assert property (@(posedge clk_sys) disable iff (rst)
		cheat_dl |=> $stable(rom_wr) && !ioctl_wait)
		else flag_violation("a cheat download started a ROM write");
	a_cheat_valid: assert property (@(posedge clk_sys) disable iff (rst)
		cheat_valid == $past(last_slot_write, 2))
		else flag_violation("cheat_valid did not follow the slot 15 write");

endmodule

// ==== verif/tb_cart_loader.sv ====
/*
 * Testbench for the cartridge loader. Runs cart and cheat downloads
 * through the DUT, answers ROM writes with a randomly delayed
 * acknowledge and checks stored bytes, read mapping and flags.
 * Enable timing and the handshake are watched in tb_checks.
 */
module tb_cart_loader;
	import cart_pkg::*;

	localparam int WAIT_LIMIT = 200;  // Cycles before any wait gives up

	logic         clk_sys;
	logic         rst;
	logic         ioctl_download;
	ioctl_index_t ioctl_index;
	logic         ioctl_wr;
	ioctl_addr_t  ioctl_addr;
	byte_t        ioctl_dout;
	logic         ioctl_wait;
	logic         rom_wr;
	rom_addr_t    rom_waddr;
	byte_t        rom_wdata;
	logic         rom_wr_ack = 1'b0;
	rom_addr_t    cpu_rom_addr;
	rom_addr_t    rom_raddr;
	logic         game_gear;
	cheat_code_t  cheat_code;
	logic         cheat_valid;
	logic         ce_cpu;
	logic         ce_vdp;
	logic         ce_pix;
	logic         ce_sp;
	logic         violation;

	int    seed = 72;
	int    ack_delay = 0;
	int    ack_wait = 0;
	byte_t sent [0:4095];       // Last cart image sent
	byte_t rom_store [0:4095];  // Bytes the store model accepted

	// Port names match the signals above
	cart_loader_top #(.HEADER_BYTES(HEADER_BYTES)) cart_loader_top_i (.*);
	tb_checks checks_i (.*, .ioctl_slot(ioctl_addr[3:0]));

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic stop_run(input string reason);
		$display("tests failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic value_error(input string test, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
		stop_run("a checked value did not match");
	endtask

	always @(posedge violation) stop_run("a protocol check in tb_checks failed");

	// ====================
	// ROM store model
	// ====================
	always @(posedge clk_sys) begin
		if (rst) begin
			rom_wr_ack <= 1'b0;
			ack_wait   <= 0;
			ack_delay  <= $unsigned($random(seed)) % 6;
		end else if (rom_wr != rom_wr_ack) begin
			if (ack_wait >= ack_delay) begin
				rom_store[rom_waddr[11:0]] <= rom_wdata;
				rom_wr_ack <= rom_wr;  // Write done
				ack_wait   <= 0;
				ack_delay  <= $unsigned($random(seed)) % 6;
			end else begin
				ack_wait <= ack_wait + 1;
			end
		end
	end

	task automatic wait_ready(input string what);
		int cycles;
		cycles = 0;
		while (ioctl_wait) begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT) stop_run($sformatf("timeout waiting for %s", what));
		end
	endtask

	task automatic wait_enables(input int pulses);
		int count;
		int cycles;
		count = 0;
		cycles = 0;
		while (count < pulses) begin
			@(posedge clk_sys);
			cycles++;
			if (ce_cpu) count++;
			if (cycles > WAIT_LIMIT) stop_run("timeout waiting for CPU clock enables");
		end
	endtask

	// Returns one edge after the DUT took the byte
	task automatic send_byte(input ioctl_addr_t offset, input byte_t data);
		wait_ready("ioctl_wait to fall");
		ioctl_addr <= offset;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic load_cart(input ioctl_index_t index, input int size);
		byte_t data;
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		assert (rom_waddr == '0) else value_error("restart address", 0, rom_waddr);
		for (int i = 0; i < size; i++) begin
			data = byte_t'($random(seed));
			sent[i] = data;
			send_byte(ioctl_addr_t'(i), data);
			assert (rom_waddr == rom_addr_t'(i)) else value_error("write address", i, rom_waddr);
			assert (rom_wdata == data) else value_error("write data", data, rom_wdata);
		end
		wait_ready("last ROM write");
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);  // cart_active falls, header flag latches
		for (int i = 0; i < size; i++) begin
			assert (rom_store[i] == sent[i]) else value_error("ROM store", sent[i], rom_store[i]);
		end
	endtask

	task automatic check_mapping(input string test, input int header, input int image);
		rom_addr_t addr;
		rom_addr_t expected;
		for (int n = 0; n < 64; n++) begin
			addr = rom_addr_t'($random(seed));
			cpu_rom_addr <= addr;
			@(posedge clk_sys);
			expected = rom_addr_t'((int'(addr) + header) % image);
			assert (rom_raddr == expected) else value_error(test, expected, rom_raddr);
		end
	endtask

	task automatic load_cheat();
		byte_t       data;
		cheat_code_t expected;
		expected = '0;
		ioctl_index    <= CHEAT_INDEX;
		ioctl_download <= 1'b1;
		@(posedge clk_sys);
		for (int k = 0; k < 16; k++) begin
			data = byte_t'($random(seed));
			// Flags field on top, low byte first within a field
			expected[(3 - k / 4) * 32 + (k % 4) * 8 +: 8] = data;
			send_byte(ioctl_addr_t'(k), data);
		end
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
		assert (cheat_valid) else value_error("cheat valid", 1, cheat_valid);
		assert (cheat_code == expected) else value_error("cheat code", expected, cheat_code);
		@(posedge clk_sys);
		assert (!cheat_valid) else value_error("cheat valid pulse", 0, cheat_valid);
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		rst            <= 1'b1;
		ioctl_download <= 1'b0;
		ioctl_index    <= '0;
		ioctl_wr       <= 1'b0;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		cpu_rom_addr   <= '0;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
		wait_enables(8);
		load_cart(8'h02, 1024);
		assert (game_gear) else value_error("game gear index 2", 1, game_gear);
		check_mapping("plain mapping", 0, 1024);
		load_cart(8'h01, 1536);
		assert (!game_gear) else value_error("game gear index 1", 0, game_gear);
		check_mapping("header mapping", HEADER_BYTES, 1024);
		load_cheat();
		repeat (4) @(posedge clk_sys);
		if (violation) begin
			stop_run("a protocol check in tb_checks failed");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// ==== files.f ====
hdl/cart_pkg.sv
hdl/ce_sequencer.sv
hdl/rom_download.sv
hdl/cart_geometry.sv
hdl/cheat_assembler.sv
hdl/cart_loader_top.sv
verif/tb_checks.sv
verif/tb_cart_loader.sv

// ==== Makefile ====
TOP := tb_cart_loader

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f hdl/*.sv verif/*.sv
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f files.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
